// File: design/credit_counter.sv
`timescale 1ns/1ps

module credit_counter (
    input  logic id_on,
    input  logic reset,
    input  logic consume,        // one beat sent downstream
    input  logic credit_return,  // one slot freed in the issue queue
    output logic has_credit
);

    logic [rename_pkg::CREDIT_W-1:0] count;
    logic                            last_in_use;

    always_ff @(posedge id_on or posedge reset) begin
        if (reset) begin
            count <= rename_pkg::ISSUE_CREDITS;
        end else begin
            case ({consume, credit_return})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    // the beat on the output already owns its credit even before the count drops,
    // so the final credit is gone one cycle early
    assign last_in_use = consume && (count == 1);
    assign has_credit  = (count != '0) && !last_in_use;

endmodule

// File: design/free_list.sv
`timescale 1ns/1ps

module free_list (
    input  logic                         id_on,
    input  logic                         reset,
    input  logic                         commit_valid,
    input  logic [rename_pkg::PHY_W-1:0] commit_phy,
    free_list_if.fifo                    fl
);

    logic [rename_pkg::PHY_W-1:0] mem [0:rename_pkg::PHY_REGS-1];

    logic [rename_pkg::PHY_W-1:0]        head;   // wraps at 128 on its own
    logic [rename_pkg::PHY_W-1:0]        tail;
    logic [rename_pkg::FREE_COUNT_W-1:0] count;

    logic                         push;
    logic [rename_pkg::PHY_W-1:0] push_phy;

    // fill and commit never overlap
    assign push     = fl.fill_valid || commit_valid;
    assign push_phy = fl.fill_valid ? fl.fill_phy : commit_phy;

    always_ff @(posedge id_on) begin
        if (push) begin
            mem[tail] <= push_phy;
        end
    end

    always_ff @(posedge id_on or posedge reset) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (fl.pop) begin
                head <= head + 1'b1;
            end
            case ({push, fl.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // oldest entry is only meaningful when not empty
    assign fl.head_phy = mem[head];
    assign fl.empty    = (count == '0);

endmodule

// File: design/free_list_if.sv
`timescale 1ns/1ps

interface free_list_if;

    logic                         fill_valid;  // initial fill push
    logic [rename_pkg::PHY_W-1:0] fill_phy;
    logic                         pop;         // rename takes head_phy
    logic [rename_pkg::PHY_W-1:0] head_phy;    // oldest free register
    logic                         empty;

    modport ctrl (
        output fill_valid,
        output fill_phy,
        input  empty
    );

    modport rat (
        output pop,
        input  head_phy,
        input  empty
    );

    modport fifo (
        input  fill_valid,
        input  fill_phy,
        input  pop,
        output head_phy,
        output empty
    );

endinterface

// File: design/reg_alias_table.sv
`timescale 1ns/1ps

module reg_alias_table (
    input  logic                         id_on,
    input  logic                         reset,
    input  logic                         accept,
    input  logic [31:0]                  instr,
    input  logic                         wb_valid,
    input  logic [rename_pkg::LOG_W-1:0] wb_logical,
    input  logic [rename_pkg::PHY_W-1:0] wb_phy,
    output logic                         out_valid,
    output logic [rename_pkg::PHY_W-1:0] out_src1_phy,
    output logic [rename_pkg::PHY_W-1:0] out_src2_phy,
    output logic [1:0]                   out_src_ready,  // bit 0 src1, bit 1 src2
    output logic [rename_pkg::PHY_W-1:0] out_rd_phy,
    output logic [rename_pkg::LOG_W-1:0] out_rd_logical,
    output logic [rename_pkg::PHY_W-1:0] out_old_phy,
    output logic                         out_has_rd,
    free_list_if.rat                     fl
);

    logic [rename_pkg::PHY_W-1:0]    map_tbl [0:rename_pkg::LOG_REGS-1];
    logic [rename_pkg::LOG_REGS-1:0] ready_tbl;

    logic [6:0]                   opcode;
    logic [rename_pkg::LOG_W-1:0] rd;
    logic [rename_pkg::LOG_W-1:0] rs1;
    logic [rename_pkg::LOG_W-1:0] rs2;
    logic                         no_src;
    logic                         one_src;
    logic                         no_dest;
    logic                         has_rd;
    logic [1:0]                   src_ready;

    // same bit positions in every format
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign no_src  = (opcode == rename_pkg::OP_LUI) || (opcode == rename_pkg::OP_AUIPC) ||
                     (opcode == rename_pkg::OP_JAL);
    assign one_src = (opcode == rename_pkg::OP_JALR) || (opcode == rename_pkg::OP_LOAD) ||
                     (opcode == rename_pkg::OP_OPIMM);
    assign no_dest = (opcode == rename_pkg::OP_BRANCH) || (opcode == rename_pkg::OP_STORE);
    assign has_rd  = !no_dest && (rd != '0);  // x0 keeps its mapping

    // unused sources look ready
    assign src_ready[0] = no_src ? 1'b1 : ready_tbl[rs1];
    assign src_ready[1] = (no_src || one_src) ? 1'b1 : ready_tbl[rs2];

    assign fl.pop = accept && has_rd;

    always_ff @(posedge id_on or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::LOG_REGS; i++) begin
                map_tbl[i] <= i[rename_pkg::PHY_W-1:0];  // identity map
            end
            ready_tbl <= '1;
        end else begin
            // stale tags no longer match the map
            if (wb_valid && !ready_tbl[wb_logical] && (map_tbl[wb_logical] == wb_phy)) begin
                ready_tbl[wb_logical] <= 1'b1;
            end
            // later write wins over a same-cycle writeback
            if (fl.pop) begin
                map_tbl[rd]   <= fl.head_phy;
                ready_tbl[rd] <= 1'b0;
            end
        end
    end

    always_ff @(posedge id_on or posedge reset) begin
        if (reset) begin
            out_valid  <= 1'b0;
            out_has_rd <= 1'b0;
        end else begin
            out_valid  <= accept;
            out_has_rd <= accept && has_rd;
        end
    end

    // lookups see the table before this edge
    always_ff @(posedge id_on) begin
        if (accept) begin
            out_src1_phy   <= map_tbl[rs1];
            out_src2_phy   <= map_tbl[rs2];
            out_src_ready  <= src_ready;
            out_rd_phy     <= has_rd ? fl.head_phy : '0;
            out_rd_logical <= rd;
            out_old_phy    <= map_tbl[rd];
        end
    end

endmodule

// File: design/rename_ctrl.sv
`timescale 1ns/1ps

module rename_ctrl (
    input  logic             id_on,
    input  logic             reset,
    input  logic             in_valid,
    input  logic             has_credit,
    output logic             in_ready,
    output logic             accept,
    free_list_if.ctrl        fl
);

    logic [1:0]                   state;
    logic [rename_pkg::PHY_W-1:0] fill_idx;     // offset from FIRST_FREE
    logic                         fill_active;  // push this cycle
    logic                         fill_last;

    // 95 for a 128 entry file
    assign fill_last = (fill_idx == rename_pkg::PHY_REGS - 1 - rename_pkg::FIRST_FREE);

    always_ff @(posedge id_on or posedge reset) begin
        if (reset) begin
            state       <= rename_pkg::ST_FILL;
            fill_idx    <= '0;
            fill_active <= 1'b0;
        end else begin
            case (state)
                rename_pkg::ST_FILL: begin
                    fill_active <= 1'b1;  // starts one cycle out of reset
                    if (fill_active) begin
                        fill_idx <= fill_idx + 1'b1;
                        if (fill_last) begin
                            fill_active <= 1'b0;
                            state       <= rename_pkg::ST_RUN;
                        end
                    end
                end
                rename_pkg::ST_RUN: begin
                    state <= rename_pkg::ST_RUN;  // no recovery path back
                end
                default: begin
                    state       <= rename_pkg::ST_FILL;
                    fill_idx    <= '0;
                    fill_active <= 1'b0;
                end
            endcase
        end
    end

    // ascending register numbers from FIRST_FREE
    assign fl.fill_valid = fill_active;
    assign fl.fill_phy   = rename_pkg::FIRST_FREE + fill_idx;

    // empty guards the pop for any rd writer
    assign in_ready = (state == rename_pkg::ST_RUN) && has_credit && !fl.empty;
    assign accept   = in_valid && in_ready;

endmodule

// File: design/rename_pkg.sv
package rename_pkg;

    // register file sizes
    localparam int LOG_W        = 5;
    localparam int PHY_W        = 7;
    localparam int LOG_REGS     = 32;
    localparam int PHY_REGS     = 128;
    localparam int FREE_COUNT_W = 8;  // must hold PHY_REGS itself

    // logical i starts on physical i, so the rest are free
    localparam logic [PHY_W-1:0] FIRST_FREE = 7'd32;

    // issue queue credits
    localparam int CREDIT_W = 4;
    localparam logic [CREDIT_W-1:0] ISSUE_CREDITS = 4'd8;

    // opcodes with no register source
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // opcodes that read rs1 only
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_OPIMM  = 7'b0010011;

    // opcodes with no destination
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;

    // controller states
    localparam logic [1:0] ST_FILL = 2'd0;
    localparam logic [1:0] ST_RUN  = 2'd1;

endpackage

// File: design/rename_top.sv
`timescale 1ns/1ps

module rename_top (
    input  logic                         id_on,
    input  logic                         reset,

    // decode side
    input  logic                         in_valid,
    output logic                         in_ready,
    input  logic [31:0]                  instr,

    // issue queue side
    output logic                         out_valid,
    output logic [rename_pkg::PHY_W-1:0] out_src1_phy,
    output logic [rename_pkg::PHY_W-1:0] out_src2_phy,
    output logic [1:0]                   out_src_ready,
    output logic [rename_pkg::PHY_W-1:0] out_rd_phy,
    output logic [rename_pkg::LOG_W-1:0] out_rd_logical,
    output logic [rename_pkg::PHY_W-1:0] out_old_phy,
    output logic                         out_has_rd,
    input  logic                         credit_return,

    // writeback and commit
    input  logic                         wb_valid,
    input  logic [rename_pkg::LOG_W-1:0] wb_logical,
    input  logic [rename_pkg::PHY_W-1:0] wb_phy,
    input  logic                         commit_valid,
    input  logic [rename_pkg::PHY_W-1:0] commit_phy
);

    logic has_credit;
    logic accept;

    free_list_if fl_if ();

    rename_ctrl u_ctrl (
        .id_on      (id_on),
        .reset      (reset),
        .in_valid   (in_valid),
        .has_credit (has_credit),
        .in_ready   (in_ready),
        .accept     (accept),
        .fl         (fl_if.ctrl)
    );

    credit_counter u_credit (
        .id_on         (id_on),
        .reset         (reset),
        .consume       (out_valid),  // one credit per output beat
        .credit_return (credit_return),
        .has_credit    (has_credit)
    );

    free_list u_free_list (
        .id_on        (id_on),
        .reset        (reset),
        .commit_valid (commit_valid),
        .commit_phy   (commit_phy),
        .fl           (fl_if.fifo)
    );

    reg_alias_table u_rat (
        .id_on          (id_on),
        .reset          (reset),
        .accept         (accept),
        .instr          (instr),
        .wb_valid       (wb_valid),
        .wb_logical     (wb_logical),
        .wb_phy         (wb_phy),
        .out_valid      (out_valid),
        .out_src1_phy   (out_src1_phy),
        .out_src2_phy   (out_src2_phy),
        .out_src_ready  (out_src_ready),
        .out_rd_phy     (out_rd_phy),
        .out_rd_logical (out_rd_logical),
        .out_old_phy    (out_old_phy),
        .out_has_rd     (out_has_rd),
        .fl             (fl_if.rat)
    );

endmodule

// File: dv/rename_tb.sv
`timescale 1ns/1ps

module rename_tb;

    localparam logic [6:0] OP_REG = 7'b0110011;  // r-type with two sources

    logic                         id_on;
    logic                         reset;
    logic                         in_valid;
    logic                         in_ready;
    logic [31:0]                  instr;
    logic                         out_valid;
    logic [rename_pkg::PHY_W-1:0] out_src1_phy;
    logic [rename_pkg::PHY_W-1:0] out_src2_phy;
    logic [1:0]                   out_src_ready;
    logic [rename_pkg::PHY_W-1:0] out_rd_phy;
    logic [rename_pkg::LOG_W-1:0] out_rd_logical;
    logic [rename_pkg::PHY_W-1:0] out_old_phy;
    logic                         out_has_rd;
    logic                         credit_return;
    logic                         wb_valid;
    logic [rename_pkg::LOG_W-1:0] wb_logical;
    logic [rename_pkg::PHY_W-1:0] wb_phy;
    logic                         commit_valid;
    logic [rename_pkg::PHY_W-1:0] commit_phy;

    // reference model
    logic [rename_pkg::PHY_W-1:0]    m_map [0:rename_pkg::LOG_REGS-1];
    logic [rename_pkg::LOG_REGS-1:0] m_ready;
    logic [rename_pkg::PHY_W-1:0]    free_q[$];
    logic [rename_pkg::PHY_W-1:0]    pending_q[$];  // old mappings awaiting commit
    int                              credits;
    int                              owed;          // credits used, not yet returned

    // expected beat for the cycle after an accept
    logic                         exp_valid;
    logic                         exp_has_rd;
    int                           exp_nsrc;
    logic [rename_pkg::PHY_W-1:0] exp_src1;
    logic [rename_pkg::PHY_W-1:0] exp_src2;
    logic [1:0]                   exp_ready;
    logic [rename_pkg::PHY_W-1:0] exp_rd_phy;
    logic [rename_pkg::LOG_W-1:0] exp_rd_log;
    logic [rename_pkg::PHY_W-1:0] exp_old_phy;

    // stimulus knobs and bookkeeping
    integer                       seed;
    int                           p_valid;
    logic                         chain_mode;
    logic                         allow_return;
    logic                         allow_commit;
    logic                         allow_wb;
    logic [rename_pkg::LOG_W-1:0] chain_rd;
    logic                         last_accept;
    int                           beats;
    int                           allocs;
    int                           no_dest_beats;
    int                           wb_hits;
    int                           wb_ignored;
    int                           errors;
    int                           waited;

    rename_top dut0 (
        .id_on          (id_on),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .instr          (instr),
        .out_valid      (out_valid),
        .out_src1_phy   (out_src1_phy),
        .out_src2_phy   (out_src2_phy),
        .out_src_ready  (out_src_ready),
        .out_rd_phy     (out_rd_phy),
        .out_rd_logical (out_rd_logical),
        .out_old_phy    (out_old_phy),
        .out_has_rd     (out_has_rd),
        .credit_return  (credit_return),
        .wb_valid       (wb_valid),
        .wb_logical     (wb_logical),
        .wb_phy         (wb_phy),
        .commit_valid   (commit_valid),
        .commit_phy     (commit_phy)
    );

    initial begin
        id_on = 1'b0;
        forever #4 id_on = ~id_on;
    end

    task automatic report_mismatch(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "run stopped at the first mismatch");
    endtask

    task automatic timeout_stop(input string msg);
        $display("TIMEOUT at %0t ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "run stopped on a timeout");
    endtask

    task automatic check_phy(input logic [rename_pkg::PHY_W-1:0] exp,
                             input logic [rename_pkg::PHY_W-1:0] act, input string what);
        if (act !== exp) begin
            report_mismatch($sformatf("%s expected %0d got %0d", what, exp, act));
        end
    endtask

    task automatic check_log(input logic [rename_pkg::LOG_W-1:0] exp,
                             input logic [rename_pkg::LOG_W-1:0] act, input string what);
        if (act !== exp) begin
            report_mismatch($sformatf("%s expected x%0d got x%0d", what, exp, act));
        end
    endtask

    task automatic check_ready(input logic [1:0] exp, input logic [1:0] act, input string what);
        if (act !== exp) begin
            report_mismatch($sformatf("%s expected %b got %b", what, exp, act));
        end
    endtask

    task automatic check_flag(input logic exp, input logic act, input string what);
        if (act !== exp) begin
            report_mismatch($sformatf("%s expected %b got %b", what, exp, act));
        end
    endtask

    function automatic int pct();
        return $unsigned($random(seed)) % 100;
    endfunction

    // mostly small registers so dependencies are common
    function automatic logic [rename_pkg::LOG_W-1:0] pick_reg();
        if (pct() < 75) begin
            return 5'($unsigned($random(seed)) % 8);
        end
        return 5'($unsigned($random(seed)) % 32);
    endfunction

    function automatic logic [6:0] pick_opcode(input int k);
        case (k)
            0:       return rename_pkg::OP_LUI;
            1:       return rename_pkg::OP_AUIPC;
            2:       return rename_pkg::OP_JAL;
            3:       return rename_pkg::OP_JALR;
            4:       return rename_pkg::OP_LOAD;
            5:       return rename_pkg::OP_OPIMM;
            6:       return rename_pkg::OP_BRANCH;
            7:       return rename_pkg::OP_STORE;
            default: return OP_REG;
        endcase
    endfunction

    function automatic logic [31:0] make_instr(input logic [6:0] opc,
                                               input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        logic [31:0] r;
        r = $random(seed);  // random funct bits
        return {r[31:25], rs2, rs1, r[14:12], rd, opc};
    endfunction

    function automatic int source_count(input logic [6:0] opc);
        if (opc == rename_pkg::OP_LUI || opc == rename_pkg::OP_AUIPC || opc == rename_pkg::OP_JAL)
            return 0;
        if (opc == rename_pkg::OP_JALR || opc == rename_pkg::OP_LOAD ||
            opc == rename_pkg::OP_OPIMM)
            return 1;
        return 2;
    endfunction

    function automatic logic writes_dest(input logic [6:0] opc, input logic [4:0] rd);
        return !(opc == rename_pkg::OP_BRANCH || opc == rename_pkg::OP_STORE) && (rd != 5'd0);
    endfunction

    // compare this cycle, then step the model across the coming edge
    task automatic check_cycle();
        logic                         accept;
        logic                         wr;
        logic [6:0]                   opc;
        logic [rename_pkg::LOG_W-1:0] rd;
        logic [rename_pkg::LOG_W-1:0] rs1;
        logic [rename_pkg::LOG_W-1:0] rs2;
        int                           nsrc;
        wr = 1'b0;
        check_flag(exp_valid, out_valid, "out_valid");
        if (exp_valid) begin
            check_flag(exp_has_rd, out_has_rd, "out_has_rd");
            check_log(exp_rd_log, out_rd_logical, "out_rd_logical");
            check_ready(exp_ready, out_src_ready, "out_src_ready");
            if (exp_nsrc >= 1) check_phy(exp_src1, out_src1_phy, "out_src1_phy");
            if (exp_nsrc == 2) check_phy(exp_src2, out_src2_phy, "out_src2_phy");
            if (exp_has_rd) begin
                check_phy(exp_rd_phy, out_rd_phy, "out_rd_phy");
                check_phy(exp_old_phy, out_old_phy, "out_old_phy");
            end
        end
        check_flag((credits > 0) && (free_q.size() > 0), in_ready, "in_ready");
        accept      = in_valid && in_ready;
        last_accept = accept;
        exp_valid   = accept;
        if (accept) begin
            opc  = instr[6:0];
            rd   = instr[11:7];
            rs1  = instr[19:15];
            rs2  = instr[24:20];
            nsrc = source_count(opc);
            wr   = writes_dest(opc, rd);
            exp_nsrc     = nsrc;
            exp_has_rd   = wr;
            exp_rd_log   = rd;
            exp_src1     = m_map[rs1];
            exp_src2     = m_map[rs2];
            exp_ready[0] = (nsrc >= 1) ? m_ready[rs1] : 1'b1;
            exp_ready[1] = (nsrc == 2) ? m_ready[rs2] : 1'b1;
            exp_old_phy  = m_map[rd];
            exp_rd_phy   = wr ? free_q[0] : '0;
            beats++;
            if (!wr) no_dest_beats++;
            credits--;
            owed++;
        end
        // writeback first so a same-edge rename clear wins
        if (wb_valid) begin
            if (!m_ready[wb_logical] && m_map[wb_logical] == wb_phy) begin
                m_ready[wb_logical] = 1'b1;
                wb_hits++;
            end else if (!m_ready[wb_logical] && m_map[wb_logical] != wb_phy) begin
                wb_ignored++;
            end
        end
        if (accept && wr) begin
            m_map[rd]   = free_q.pop_front();
            m_ready[rd] = 1'b0;
            pending_q.push_back(exp_old_phy);
            allocs++;
        end
        if (commit_valid) free_q.push_back(commit_phy);
        if (credit_return) credits++;
    endtask

    task automatic drive_inputs();
        logic [rename_pkg::LOG_W-1:0] l;
        logic [rename_pkg::LOG_W-1:0] rs1;
        // a stalled instruction stays on the bus
        if (!(in_valid && !last_accept)) begin
            in_valid <= (pct() < p_valid);
            if (chain_mode) begin
                rs1      = chain_rd;
                chain_rd = (chain_rd == 5'd31) ? 5'd1 : chain_rd + 5'd1;
                instr    <= make_instr(OP_REG, chain_rd, rs1, 5'd0);
            end else begin
                instr <= make_instr(pick_opcode(pct() % 9), pick_reg(), pick_reg(), pick_reg());
            end
        end
        if (allow_return && owed > 0 && pct() < 50) begin
            credit_return <= 1'b1;
            owed--;
        end else begin
            credit_return <= 1'b0;
        end
        if (allow_commit && pending_q.size() > 0 && pct() < 35) begin
            commit_valid <= 1'b1;
            commit_phy   <= pending_q.pop_front();
        end else begin
            commit_valid <= 1'b0;
        end
        if (allow_wb && pct() < 50) begin
            l = pick_reg();
            wb_valid   <= 1'b1;
            wb_logical <= l;
            wb_phy     <= (pct() < 50) ? m_map[l] : 7'($unsigned($random(seed)) % 128);
        end else begin
            wb_valid <= 1'b0;
        end
    endtask

    task automatic run_cycles(input int n);
        int c;
        for (c = 0; c < n; c++) begin
            @(negedge id_on);
            check_cycle();
            @(posedge id_on);
            drive_inputs();
        end
    endtask

    initial begin
        seed          = 32'ha1ad_3756;
        reset         = 1'b1;
        in_valid      = 1'b0;
        instr         = '0;
        credit_return = 1'b0;
        wb_valid      = 1'b0;
        wb_logical    = '0;
        wb_phy        = '0;
        commit_valid  = 1'b0;
        commit_phy    = '0;
        p_valid       = 0;
        chain_mode    = 1'b1;
        allow_return  = 1'b0;
        allow_commit  = 1'b0;
        allow_wb      = 1'b0;
        chain_rd      = '0;
        last_accept   = 1'b0;
        exp_valid     = 1'b0;
        credits       = rename_pkg::ISSUE_CREDITS;
        owed          = 0;
        beats         = 0;
        allocs        = 0;
        no_dest_beats = 0;
        wb_hits       = 0;
        wb_ignored    = 0;
        errors        = 0;
        for (int i = 0; i < rename_pkg::LOG_REGS; i++) m_map[i] = i;  // identity after reset
        m_ready = '1;
        for (int p = rename_pkg::FIRST_FREE; p < rename_pkg::PHY_REGS; p++) free_q.push_back(p);

        repeat (10) @(posedge id_on);
        reset <= 1'b0;

        // in_ready stays low until all 96 are pushed
        waited = 0;
        @(negedge id_on);
        while (!in_ready) begin
            if (waited == 300) timeout_stop("in_ready never rose after the free list fill");
            @(negedge id_on);
            waited++;
        end
        check_flag(1'b1, waited >= 96, "fill lasted at least 96 cycles");

        // dependent chain with no credit returns
        p_valid = 100;
        run_cycles(30);
        check_flag(1'b1, beats == rename_pkg::ISSUE_CREDITS, "beats limited by credits");

        // returns resume renaming until the free list runs dry
        allow_return = 1'b1;
        waited = 0;
        while (free_q.size() != 0) begin
            if (waited == 2000) timeout_stop("free list never ran dry");
            run_cycles(1);
            waited++;
        end
        run_cycles(20);
        check_flag(1'b1, allocs == rename_pkg::PHY_REGS - rename_pkg::FIRST_FREE,
                   "allocations before the free list ran dry");

        // random traffic where commits reuse registers in order
        chain_mode   = 1'b0;
        p_valid      = 70;
        allow_commit = 1'b1;
        allow_wb     = 1'b1;
        run_cycles(3000);

        check_flag(1'b1, wb_hits > 0, "some writeback set a ready bit");
        check_flag(1'b1, wb_ignored > 0, "some stale writeback was ignored");
        check_flag(1'b1, no_dest_beats > 0, "some beat had no destination");
        check_flag(1'b1, allocs > 200, "registers were reused after commit");

        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: sim.f
design/rename_pkg.sv
design/free_list_if.sv
design/rename_ctrl.sv
design/credit_counter.sv
design/free_list.sv
design/reg_alias_table.sv
design/rename_top.sv
dv/rename_tb.sv
